// File: verilog/fm_reg_config.svh
`ifndef FM_REG_CONFIG_SVH
`define FM_REG_CONFIG_SVH

// operator slots in one frame, four operators by six channels
`define FM_SLOTS 24

// channels, codes 0,1,2,4,5,6
`define FM_CHANS 6

// total level after reset, 127 is silent
`define FM_TL_RST 7'd127

// pan after reset, left and right both on
`define FM_RL_RST 2'b11

`endif

// File: verilog/fm_reg_pkg.sv
package fm_reg_pkg;

	typedef logic [2:0]  ch_t;
	typedef logic [1:0]  op_t;
	typedef logic [10:0] fnum_t;
	typedef logic [2:0]  block_t;
	typedef logic [2:0]  alg_t;
	typedef logic [2:0]  fb_t;
	typedef logic [1:0]  rl_t;
	typedef logic [6:0]  tl_t;
	typedef logic [4:0]  rate_t;
	typedef logic [3:0]  nib_t;
	typedef logic [2:0]  dt_t;
	typedef logic [1:0]  ks_t;
	typedef logic [7:0]  data_t;

	// channel result: fnum, block, alg, fb, rl
	typedef logic [21:0] chan_vec_t;
	// operator result: dt, mul, tl, ks, ar, d1r, d1l, rr
	typedef logic [33:0] oper_vec_t;

	// channel kinds first, then operator kinds
	typedef enum logic [3:0] {
		kind_fnum_hi,
		kind_fnum_lo,
		kind_alg_fb,
		kind_pan,
		kind_dt_mul,
		kind_tl,
		kind_ks_ar,
		kind_d1r,
		kind_d1l_rr
	} reg_kind_t;

	function automatic logic is_chan_kind(reg_kind_t kind);
		return kind inside {kind_fnum_hi, kind_fnum_lo, kind_alg_fb, kind_pan};
	endfunction

	// codes 4..6 fold onto entries 3..5
	function automatic logic [2:0] ch_index(ch_t ch);
		return ch[2] ? ({1'b0, ch[1:0]} + 3'd3) : {1'b0, ch[1:0]};
	endfunction

endpackage

// File: verilog/fm_slot_if.sv
interface fm_slot_if;
	import fm_reg_pkg::*;

	// slot being served this cycle
	ch_t       cur_ch;
	op_t       cur_op;

	// pending host write, commit marks its slot
	logic      commit;
	reg_kind_t kind;
	data_t     data;

	// slot step enable
	logic      adv;

	modport seq (
		output cur_ch, cur_op, commit, kind, data, adv
	);

	modport regs (
		input cur_ch, cur_op, commit, kind, data, adv
	);

endinterface

// File: verilog/fm_slot_seq.sv
module fm_slot_seq (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clk_en,
	input  logic                  wr,
	input  fm_reg_pkg::reg_kind_t wr_kind,
	input  fm_reg_pkg::ch_t       wr_ch,
	input  fm_reg_pkg::op_t       wr_op,
	input  fm_reg_pkg::data_t     wr_data,
	output logic                  busy,
	fm_slot_if.seq                slot
);
	import fm_reg_pkg::*;

	ch_t       cur_ch;
	op_t       cur_op;
	ch_t       next_ch;
	op_t       next_op;

	ch_t       pend_ch;
	op_t       pend_op;
	reg_kind_t pend_kind;
	data_t     pend_data;

	logic      accept;
	logic      hit;

	// channel order 0,1,2,4,5,6; 6 wraps to 0 through the add
	always_comb begin
		if (cur_ch[1:0] == 2'b10) begin
			next_ch = cur_ch + 3'd2;
		end else begin
			next_ch = cur_ch + 3'd1;
		end
		// operator steps once channel 6 is done
		if (cur_ch == 3'd6) begin
			next_op = cur_op + 2'd1;
		end else begin
			next_op = cur_op;
		end
	end

	assign accept = wr && !busy;

	// channel kinds ignore the operator field
	assign hit = busy && (pend_ch == cur_ch) &&
		(is_chan_kind(pend_kind) || (pend_op == cur_op));

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_ch <= '0;
			cur_op <= '0;
			busy   <= 1'b0;
		end else begin
			if (clk_en) begin
				cur_ch <= next_ch;
				cur_op <= next_op;
			end
			if (accept) begin
				busy <= 1'b1;
			end else if (hit && clk_en) begin
				busy <= 1'b0;
			end
		end
	end

	// single pending write
	always_ff @(posedge clk) begin
		if (accept) begin
			pend_kind <= wr_kind;
			pend_ch   <= wr_ch;
			pend_op   <= wr_op;
			pend_data <= wr_data;
		end
	end

	assign slot.cur_ch = cur_ch;
	assign slot.cur_op = cur_op;
	// stays up while the slot is frozen, files qualify it with adv
	assign slot.commit = hit;
	assign slot.kind   = pend_kind;
	assign slot.data   = pend_data;
	assign slot.adv    = clk_en;

endmodule

// File: verilog/fm_chan_regs.sv
`include "fm_reg_config.svh"

module fm_chan_regs (
	input  logic                  clk,
	input  logic                  rst,
	fm_slot_if.regs               slot,
	output fm_reg_pkg::chan_vec_t chan
);
	import fm_reg_pkg::*;

	fnum_t      fnum_q  [`FM_CHANS];
	block_t     block_q [`FM_CHANS];
	alg_t       alg_q   [`FM_CHANS];
	fb_t        fb_q    [`FM_CHANS];
	rl_t        rl_q    [`FM_CHANS];

	// high byte waits here until the low byte arrives
	block_t     blk_lat [`FM_CHANS];
	logic [2:0] fhi_lat [`FM_CHANS];

	logic [2:0] idx;
	logic       we;

	assign idx = ch_index(slot.cur_ch);
	assign we  = slot.commit && slot.adv && is_chan_kind(slot.kind);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FM_CHANS; i++) begin
				fnum_q[i]  <= '0;
				block_q[i] <= '0;
				alg_q[i]   <= '0;
				fb_q[i]    <= '0;
				rl_q[i]    <= `FM_RL_RST;
				blk_lat[i] <= '0;
				fhi_lat[i] <= '0;
			end
		end else if (we) begin
			case (slot.kind)
				kind_fnum_hi: begin
					blk_lat[idx] <= slot.data[5:3];
					fhi_lat[idx] <= slot.data[2:0];
				end
				kind_fnum_lo: begin
					block_q[idx] <= blk_lat[idx];
					fnum_q[idx]  <= {fhi_lat[idx], slot.data};
				end
				kind_alg_fb: begin
					fb_q[idx]  <= slot.data[5:3];
					alg_q[idx] <= slot.data[2:0];
				end
				kind_pan: begin
					rl_q[idx] <= slot.data[7:6];
				end
				default: begin
				end
			endcase
		end
	end

	// entry of the current channel
	assign chan = {fnum_q[idx], block_q[idx], alg_q[idx], fb_q[idx], rl_q[idx]};

endmodule

// File: verilog/fm_op_regs.sv
`include "fm_reg_config.svh"

module fm_op_regs (
	input  logic                  clk,
	input  logic                  rst,
	fm_slot_if.regs               slot,
	output fm_reg_pkg::oper_vec_t oper
);
	import fm_reg_pkg::*;

	dt_t   dt_q  [`FM_SLOTS];
	nib_t  mul_q [`FM_SLOTS];
	tl_t   tl_q  [`FM_SLOTS];
	ks_t   ks_q  [`FM_SLOTS];
	rate_t ar_q  [`FM_SLOTS];
	rate_t d1r_q [`FM_SLOTS];
	nib_t  d1l_q [`FM_SLOTS];
	nib_t  rr_q  [`FM_SLOTS];

	logic [4:0] idx;
	logic       we;

	// operator-major layout, six channel entries per operator
	assign idx = ({3'b000, slot.cur_op} * 5'd6) + {2'b00, ch_index(slot.cur_ch)};
	assign we  = slot.commit && slot.adv && !is_chan_kind(slot.kind);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FM_SLOTS; i++) begin
				dt_q[i]  <= '0;
				mul_q[i] <= '0;
				tl_q[i]  <= `FM_TL_RST;
				ks_q[i]  <= '0;
				ar_q[i]  <= '0;
				d1r_q[i] <= '0;
				d1l_q[i] <= '0;
				rr_q[i]  <= '0;
			end
		end else if (we) begin
			// only the fields of the committed kind change
			case (slot.kind)
				kind_dt_mul: begin
					dt_q[idx]  <= slot.data[6:4];
					mul_q[idx] <= slot.data[3:0];
				end
				kind_tl: begin
					tl_q[idx] <= slot.data[6:0];
				end
				kind_ks_ar: begin
					ks_q[idx] <= slot.data[7:6];
					ar_q[idx] <= slot.data[4:0];
				end
				kind_d1r: begin
					d1r_q[idx] <= slot.data[4:0];
				end
				kind_d1l_rr: begin
					d1l_q[idx] <= slot.data[7:4];
					rr_q[idx]  <= slot.data[3:0];
				end
				default: begin
				end
			endcase
		end
	end

	assign oper = {
		dt_q[idx],
		mul_q[idx],
		tl_q[idx],
		ks_q[idx],
		ar_q[idx],
		d1r_q[idx],
		d1l_q[idx],
		rr_q[idx]
	};

endmodule

// File: verilog/fm_slot_merge.sv
module fm_slot_merge (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clk_en,
	input  fm_reg_pkg::ch_t       cur_ch,
	input  fm_reg_pkg::op_t       cur_op,
	input  fm_reg_pkg::chan_vec_t chan,
	input  fm_reg_pkg::oper_vec_t oper,
	input  logic                  effect,
	input  fm_reg_pkg::fnum_t     fnum_ch3op1,
	input  fm_reg_pkg::fnum_t     fnum_ch3op2,
	input  fm_reg_pkg::fnum_t     fnum_ch3op3,
	input  fm_reg_pkg::block_t    block_ch3op1,
	input  fm_reg_pkg::block_t    block_ch3op2,
	input  fm_reg_pkg::block_t    block_ch3op3,
	output logic                  out_valid,
	output fm_reg_pkg::ch_t       out_ch,
	output fm_reg_pkg::op_t       out_op,
	output fm_reg_pkg::fnum_t     fnum,
	output fm_reg_pkg::block_t    block,
	output fm_reg_pkg::alg_t      alg,
	output fm_reg_pkg::fb_t       fb,
	output fm_reg_pkg::rl_t       rl,
	output fm_reg_pkg::dt_t       dt,
	output fm_reg_pkg::nib_t      mul,
	output fm_reg_pkg::tl_t       tl,
	output fm_reg_pkg::ks_t       ks,
	output fm_reg_pkg::rate_t     ar,
	output fm_reg_pkg::rate_t     d1r,
	output fm_reg_pkg::nib_t      d1l,
	output fm_reg_pkg::nib_t      rr,
	output logic                  mod_op1,
	output logic                  mod_op2,
	output logic                  mod_op3
);
	import fm_reg_pkg::*;

	fnum_t  fnum_raw;
	block_t block_raw;
	alg_t   alg_c;
	fb_t    fb_c;
	rl_t    rl_c;

	fnum_t  fnum_sel;
	block_t block_sel;
	logic   eff_on;
	logic   s2, s3, s4;
	logic   m1, m2, m3;

	assign {fnum_raw, block_raw, alg_c, fb_c, rl_c} = chan;

	// operator numbers 0..3 are stages s1, s3, s2, s4
	assign s3 = (cur_op == 2'd1);
	assign s2 = (cur_op == 2'd2);
	assign s4 = (cur_op == 2'd3);

	// ch3 effect mode, fourth operator keeps the channel frequency
	assign eff_on = effect && (cur_ch == 3'd2);

	always_comb begin
		fnum_sel  = fnum_raw;
		block_sel = block_raw;
		if (eff_on) begin
			case (cur_op)
				2'd0: begin
					fnum_sel  = fnum_ch3op1;
					block_sel = block_ch3op1;
				end
				2'd1: begin
					fnum_sel  = fnum_ch3op3;
					block_sel = block_ch3op3;
				end
				2'd2: begin
					fnum_sel  = fnum_ch3op2;
					block_sel = block_ch3op2;
				end
				default: begin
				end
			endcase
		end
	end

	// which earlier stage feeds the stage in this slot
	always_comb begin
		m1 = 1'b0;
		m2 = 1'b0;
		m3 = 1'b0;
		case (alg_c)
			3'd0: begin
				m1 = s2;
				m2 = s3;
				m3 = s4;
			end
			3'd1: begin
				m1 = s3;
				m2 = s3;
				m3 = s4;
			end
			3'd2: begin
				m1 = s4;
				m2 = s3;
				m3 = s4;
			end
			3'd3: begin
				m1 = s2;
				m2 = s4;
				m3 = s4;
			end
			3'd4: begin
				m1 = s2;
				m3 = s4;
			end
			3'd5: m1 = s2 || s3 || s4;
			3'd6: m1 = s2;
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= clk_en;
		end
	end

	always_ff @(posedge clk) begin
		if (clk_en) begin
			out_ch  <= cur_ch;
			out_op  <= cur_op;
			fnum    <= fnum_sel;
			block   <= block_sel;
			alg     <= alg_c;
			fb      <= fb_c;
			rl      <= rl_c;
			{dt, mul, tl, ks, ar, d1r, d1l, rr} <= oper;
			mod_op1 <= m1;
			mod_op2 <= m2;
			mod_op3 <= m3;
		end
	end

endmodule

// File: verilog/fm_reg_top.sv
module fm_reg_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clk_en,
	input  logic                  wr,
	input  fm_reg_pkg::reg_kind_t wr_kind,
	input  fm_reg_pkg::ch_t       wr_ch,
	input  fm_reg_pkg::op_t       wr_op,
	input  fm_reg_pkg::data_t     wr_data,
	output logic                  busy,
	input  logic                  effect,
	input  fm_reg_pkg::fnum_t     fnum_ch3op1,
	input  fm_reg_pkg::fnum_t     fnum_ch3op2,
	input  fm_reg_pkg::fnum_t     fnum_ch3op3,
	input  fm_reg_pkg::block_t    block_ch3op1,
	input  fm_reg_pkg::block_t    block_ch3op2,
	input  fm_reg_pkg::block_t    block_ch3op3,
	output logic                  out_valid,
	output fm_reg_pkg::ch_t       out_ch,
	output fm_reg_pkg::op_t       out_op,
	output fm_reg_pkg::fnum_t     fnum,
	output fm_reg_pkg::block_t    block,
	output fm_reg_pkg::alg_t      alg,
	output fm_reg_pkg::fb_t       fb,
	output fm_reg_pkg::rl_t       rl,
	output fm_reg_pkg::dt_t       dt,
	output fm_reg_pkg::nib_t      mul,
	output fm_reg_pkg::tl_t       tl,
	output fm_reg_pkg::ks_t       ks,
	output fm_reg_pkg::rate_t     ar,
	output fm_reg_pkg::rate_t     d1r,
	output fm_reg_pkg::nib_t      d1l,
	output fm_reg_pkg::nib_t      rr,
	output logic                  mod_op1,
	output logic                  mod_op2,
	output logic                  mod_op3
);
	import fm_reg_pkg::*;

	chan_vec_t chan;
	oper_vec_t oper;

	fm_slot_if slot_bus ();

	fm_slot_seq seq_i (
		.clk     (clk),
		.rst     (rst),
		.clk_en  (clk_en),
		.wr      (wr),
		.wr_kind (wr_kind),
		.wr_ch   (wr_ch),
		.wr_op   (wr_op),
		.wr_data (wr_data),
		.busy    (busy),
		.slot    (slot_bus.seq)
	);

	fm_chan_regs chan_i (
		.clk  (clk),
		.rst  (rst),
		.slot (slot_bus.regs),
		.chan (chan)
	);

	fm_op_regs op_i (
		.clk  (clk),
		.rst  (rst),
		.slot (slot_bus.regs),
		.oper (oper)
	);

	fm_slot_merge merge_i (
		.clk          (clk),
		.rst          (rst),
		.clk_en       (clk_en),
		.cur_ch       (slot_bus.cur_ch),
		.cur_op       (slot_bus.cur_op),
		.chan         (chan),
		.oper         (oper),
		.effect       (effect),
		.fnum_ch3op1  (fnum_ch3op1),
		.fnum_ch3op2  (fnum_ch3op2),
		.fnum_ch3op3  (fnum_ch3op3),
		.block_ch3op1 (block_ch3op1),
		.block_ch3op2 (block_ch3op2),
		.block_ch3op3 (block_ch3op3),
		.out_valid    (out_valid),
		.out_ch       (out_ch),
		.out_op       (out_op),
		.fnum         (fnum),
		.block        (block),
		.alg          (alg),
		.fb           (fb),
		.rl           (rl),
		.dt           (dt),
		.mul          (mul),
		.tl           (tl),
		.ks           (ks),
		.ar           (ar),
		.d1r          (d1r),
		.d1l          (d1l),
		.rr           (rr),
		.mod_op1      (mod_op1),
		.mod_op2      (mod_op2),
		.mod_op3      (mod_op3)
	);

endmodule

// File: sim/fm_reg_tb.sv
`include "fm_reg_config.svh"

module fm_reg_tb;
	import fm_reg_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_WRITES = 42;
	localparam int NUM_FRAMES = 16;
	// each write may wait up to a frame, plus the idle frames and reset
	localparam int WATCHDOG_TIME =
		((NUM_WRITES * 2 + NUM_FRAMES) * `FM_SLOTS + 200) * CLK_PERIOD;

	logic      clk = 1'b0;
	logic      rst;
	logic      clk_en;
	logic      wr;
	reg_kind_t wr_kind;
	ch_t       wr_ch;
	op_t       wr_op;
	data_t     wr_data;
	logic      busy;
	logic      effect;
	fnum_t     fnum_ch3op1, fnum_ch3op2, fnum_ch3op3;
	block_t    block_ch3op1, block_ch3op2, block_ch3op3;
	logic      out_valid;
	ch_t       out_ch;
	op_t       out_op;
	fnum_t     fnum;
	block_t    block;
	alg_t      alg;
	fb_t       fb;
	rl_t       rl;
	dt_t       dt;
	nib_t      mul;
	tl_t       tl;
	ks_t       ks;
	rate_t     ar;
	rate_t     d1r;
	nib_t      d1l;
	nib_t      rr;
	logic      mod_op1, mod_op2, mod_op3;

	int seed = 32'hddc3_5292;

	// expected register contents, channel entries by position 0..5
	fnum_t      m_fnum    [`FM_CHANS];
	block_t     m_block   [`FM_CHANS];
	alg_t       m_alg     [`FM_CHANS];
	fb_t        m_fb      [`FM_CHANS];
	rl_t        m_rl      [`FM_CHANS];
	block_t     m_blk_lat [`FM_CHANS];
	logic [2:0] m_fhi_lat [`FM_CHANS];
	dt_t        m_dt      [`FM_SLOTS];
	nib_t       m_mul     [`FM_SLOTS];
	tl_t        m_tl      [`FM_SLOTS];
	ks_t        m_ks      [`FM_SLOTS];
	rate_t      m_ar      [`FM_SLOTS];
	rate_t      m_d1r     [`FM_SLOTS];
	nib_t       m_d1l     [`FM_SLOTS];
	nib_t       m_rr      [`FM_SLOTS];

	// monitor state
	logic exp_valid = 1'b0;
	logic eff_seen = 1'b0;
	int   exp_pos;
	op_t  exp_op;
	int   beats = 0;
	int   checks = 0;
	int   data_errors = 0;
	int   flow_errors = 0;

	fm_reg_top dut_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired before the tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

	// channel codes skip 3 and 7
	function automatic ch_t code_of(int pos);
		return (pos < 3) ? 3'(pos) : 3'(pos + 1);
	endfunction

	function automatic int pos_of(ch_t ch);
		return (ch > 3'd3) ? int'(ch) - 1 : int'(ch);
	endfunction

	function automatic int slot_of(ch_t ch, op_t op);
		return int'(op) * 6 + pos_of(ch);
	endfunction

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic data_t rand_byte();
		return 8'($random(seed));
	endfunction

	// returns {mod_op3, mod_op2, mod_op1}; op numbers 0..3 are stages s1, s3, s2, s4
	function automatic logic [2:0] expected_mods(alg_t a, op_t op);
		logic [5:0] e;
		logic [2:0] m;
		// edges {1>2, 1>3, 1>4, 2>3, 2>4, 3>4}
		case (a)
			3'd0: e = 6'b100101;
			3'd1: e = 6'b010101;
			3'd2: e = 6'b001101;
			3'd3: e = 6'b100011;
			3'd4: e = 6'b100001;
			3'd5: e = 6'b111000;
			3'd6: e = 6'b100000;
			default: e = 6'b000000;
		endcase
		m = 3'b000;
		case (op)
			2'd2: m[0] = e[5];
			2'd1: begin
				m[0] = e[4];
				m[1] = e[2];
			end
			2'd3: begin
				m[0] = e[3];
				m[1] = e[1];
				m[2] = e[0];
			end
			default: begin
			end
		endcase
		return m;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < `FM_CHANS; i++) begin
			m_fnum[i] = '0;
			m_block[i] = '0;
			m_alg[i] = '0;
			m_fb[i] = '0;
			m_rl[i] = 2'b11;
			m_blk_lat[i] = '0;
			m_fhi_lat[i] = '0;
		end
		for (int i = 0; i < `FM_SLOTS; i++) begin
			m_dt[i] = '0;
			m_mul[i] = '0;
			m_tl[i] = 7'd127;
			m_ks[i] = '0;
			m_ar[i] = '0;
			m_d1r[i] = '0;
			m_d1l[i] = '0;
			m_rr[i] = '0;
		end
	endtask

	task automatic apply_write(reg_kind_t kind, ch_t ch, op_t op, data_t d);
		int c;
		int s;
		c = pos_of(ch);
		s = slot_of(ch, op);
		case (kind)
			kind_fnum_hi: begin
				m_blk_lat[c] = d[5:3];
				m_fhi_lat[c] = d[2:0];
			end
			kind_fnum_lo: begin
				m_block[c] = m_blk_lat[c];
				m_fnum[c] = {m_fhi_lat[c], d};
			end
			kind_alg_fb: begin
				m_fb[c] = d[5:3];
				m_alg[c] = d[2:0];
			end
			kind_pan: m_rl[c] = d[7:6];
			kind_dt_mul: begin
				m_dt[s] = d[6:4];
				m_mul[s] = d[3:0];
			end
			kind_tl: m_tl[s] = d[6:0];
			kind_ks_ar: begin
				m_ks[s] = d[7:6];
				m_ar[s] = d[4:0];
			end
			kind_d1r: m_d1r[s] = d[4:0];
			kind_d1l_rr: begin
				m_d1l[s] = d[7:4];
				m_rr[s] = d[3:0];
			end
		endcase
	endtask

	task automatic check_field(string name, logic [31:0] got, logic [31:0] want);
		checks++;
		assert (got == want) else begin
			data_errors++;
			$display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, want);
		end
	endtask

	task automatic check_beat();
		int         c;
		int         s;
		fnum_t      f;
		block_t     b;
		logic [2:0] m;
		c = pos_of(out_ch);
		s = slot_of(out_ch, out_op);
		f = m_fnum[c];
		b = m_block[c];
		// ch3 effect mode, operator 3 keeps the channel value
		if (eff_seen && out_ch == 3'd2) begin
			case (out_op)
				2'd0: begin
					f = fnum_ch3op1;
					b = block_ch3op1;
				end
				2'd2: begin
					f = fnum_ch3op2;
					b = block_ch3op2;
				end
				2'd1: begin
					f = fnum_ch3op3;
					b = block_ch3op3;
				end
				default: begin
				end
			endcase
		end
		m = expected_mods(m_alg[c], out_op);
		check_field("fnum", 32'(fnum), 32'(f));
		check_field("block", 32'(block), 32'(b));
		check_field("alg", 32'(alg), 32'(m_alg[c]));
		check_field("fb", 32'(fb), 32'(m_fb[c]));
		check_field("rl", 32'(rl), 32'(m_rl[c]));
		check_field("dt", 32'(dt), 32'(m_dt[s]));
		check_field("mul", 32'(mul), 32'(m_mul[s]));
		check_field("tl", 32'(tl), 32'(m_tl[s]));
		check_field("ks", 32'(ks), 32'(m_ks[s]));
		check_field("ar", 32'(ar), 32'(m_ar[s]));
		check_field("d1r", 32'(d1r), 32'(m_d1r[s]));
		check_field("d1l", 32'(d1l), 32'(m_d1l[s]));
		check_field("rr", 32'(rr), 32'(m_rr[s]));
		check_field("mod_op1", 32'(mod_op1), 32'(m[0]));
		check_field("mod_op2", 32'(mod_op2), 32'(m[1]));
		check_field("mod_op3", 32'(mod_op3), 32'(m[2]));
	endtask

	// what the output registers should have captured at the last edge
	always @(posedge clk) begin
		exp_valid <= !rst && clk_en;
		eff_seen <= effect;
	end

	// outputs are compared half a cycle after they change
	always @(negedge clk) begin
		if (rst) begin
			exp_pos = 0;
			exp_op = 2'd0;
		end else begin
			check_field("out_valid", 32'(out_valid), 32'(exp_valid));
			if (out_valid) begin
				beats++;
				assert (out_ch == code_of(exp_pos) && out_op == exp_op) begin
					check_beat();
				end else begin
					data_errors++;
					$display("[ERROR] %0t out_ch/out_op: got %0d/%0d expected %0d/%0d",
						$time, out_ch, out_op, code_of(exp_pos), exp_op);
				end
				exp_pos++;
				if (exp_pos == 6) begin
					exp_pos = 0;
					exp_op = exp_op + 2'd1;
				end
			end
		end
	end

	task automatic wait_idle();
		@(negedge clk);
		while (busy) begin
			@(negedge clk);
		end
	endtask

	task automatic drive_wr(reg_kind_t kind, ch_t ch, op_t op, data_t d);
		@(posedge clk);
		wr <= 1'b1;
		wr_kind <= kind;
		wr_ch <= ch;
		wr_op <= op;
		wr_data <= d;
		@(posedge clk);
		wr <= 1'b0;
	endtask

	task automatic wait_commit();
		int n;
		n = 0;
		@(negedge clk);
		while (busy && n < 64) begin
			n++;
			@(negedge clk);
		end
		if (busy) begin
			flow_errors++;
			$display("write was never committed, busy still high after %0d cycles", n);
		end else begin
			assert (n <= `FM_SLOTS) else begin
				flow_errors++;
				$display("write took %0d cycles to commit, longer than one frame", n);
			end
		end
	endtask

	task automatic write_reg(reg_kind_t kind, ch_t ch, op_t op, data_t d);
		wait_idle();
		drive_wr(kind, ch, op, d);
		wait_commit();
		// the committed slot's own beat still shows the old value
		@(posedge clk);
		apply_write(kind, ch, op, d);
	endtask

	task automatic run_frames(int n);
		repeat (n * `FM_SLOTS + 2) @(negedge clk);
	endtask

	task automatic reset_frame();
		run_frames(1);
		assert (beats >= `FM_SLOTS) else begin
			flow_errors++;
			$display("only %0d output beats seen in the first frame after reset", beats);
		end
	endtask

	task automatic operator_writes();
		reg_kind_t kind;
		for (int k = 0; k < 5; k++) begin
			kind = reg_kind_t'(4'(k + 4));
			repeat (4) begin
				write_reg(kind, code_of(rand_below(6)), 2'(rand_below(4)), rand_byte());
			end
		end
		run_frames(1);
	endtask

	task automatic frequency_latch();
		ch_t ch;
		ch = code_of(rand_below(6));
		// nonzero block so a premature update would show
		write_reg(kind_fnum_hi, ch, 2'd0, {2'b00, 3'(1 + rand_below(7)), 3'(rand_below(8))});
		run_frames(1);
		write_reg(kind_fnum_lo, ch, 2'd0, rand_byte());
		run_frames(1);
	endtask

	task automatic algorithm_sweep();
		for (int a = 0; a < 8; a++) begin
			write_reg(kind_alg_fb, code_of(a % 6), 2'd0,
				{2'b00, 3'(rand_below(8)), 3'(a)});
			write_reg(kind_pan, code_of(a % 6), 2'd0,
				{2'(rand_below(4)), 6'(rand_below(64))});
			run_frames(1);
		end
	endtask

	task automatic effect_mode();
		write_reg(kind_fnum_hi, 3'd2, 2'd0, {2'b00, 3'(rand_below(8)), 3'(rand_below(8))});
		write_reg(kind_fnum_lo, 3'd2, 2'd0, rand_byte());
		@(posedge clk);
		effect <= 1'b1;
		run_frames(2);
		@(posedge clk);
		effect <= 1'b0;
		run_frames(1);
	endtask

	task automatic busy_write();
		ch_t   ch_a, ch_b;
		op_t   op_a, op_b;
		data_t d_a, d_b;
		ch_a = code_of(rand_below(6));
		op_a = 2'(rand_below(4));
		d_a = rand_byte();
		ch_b = code_of(rand_below(6));
		op_b = op_a + 2'd1;
		d_b = 8'({1'b0, ~m_tl[slot_of(ch_b, op_b)]});
		wait_idle();
		// frozen slot keeps the first write pending
		@(posedge clk);
		clk_en <= 1'b0;
		drive_wr(kind_tl, ch_a, op_a, d_a);
		drive_wr(kind_tl, ch_b, op_b, d_b);
		repeat (8) begin
			@(negedge clk);
			assert (busy) else begin
				flow_errors++;
				$display("[ERROR] %0t busy: got 0 expected 1", $time);
			end
		end
		@(posedge clk);
		clk_en <= 1'b1;
		wait_commit();
		@(posedge clk);
		apply_write(kind_tl, ch_a, op_a, d_a);
		run_frames(1);
	endtask

	initial begin
		rst <= 1'b1;
		clk_en <= 1'b1;
		wr <= 1'b0;
		wr_kind <= kind_fnum_hi;
		wr_ch <= 3'd0;
		wr_op <= 2'd0;
		wr_data <= 8'h00;
		effect <= 1'b0;
		fnum_ch3op1 <= 11'($random(seed));
		fnum_ch3op2 <= 11'($random(seed));
		fnum_ch3op3 <= 11'($random(seed));
		block_ch3op1 <= 3'($random(seed));
		block_ch3op2 <= 3'($random(seed));
		block_ch3op3 <= 3'($random(seed));
		model_reset();
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		reset_frame();
		operator_writes();
		frequency_latch();
		algorithm_sweep();
		effect_mode();
		busy_write();

		$display("summary: %0d beats, %0d checks, %0d data errors, %0d flow errors",
			beats, checks, data_errors, flow_errors);
		if (data_errors == 0 && flow_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+verilog
verilog/fm_reg_pkg.sv
verilog/fm_slot_if.sv
verilog/fm_slot_seq.sv
verilog/fm_chan_regs.sv
verilog/fm_op_regs.sv
verilog/fm_slot_merge.sv
verilog/fm_reg_top.sv
sim/fm_reg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the FM register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f tb.f --top-module fm_reg_tb \
	-Mdir "$build_dir" -o fm_reg_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/fm_reg_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation finished: PASS$" "$log_file"; then
	echo "result: pass"
	exit 0
fi
echo "result: fail"
exit 1
